/* exu_alu.f */
hdl/exu_alu_pkg.sv
hdl/alu_disp.sv
hdl/alu_rglr.sv
hdl/alu_bjp.sv
hdl/alu_dpath.sv
hdl/alu_wbck_arbt.sv
hdl/exu_alu_top.sv
+incdir+verif
verif/tb_exu_alu.sv

/* hdl/alu_bjp.sv */
// Branch and jump unit: compare request, resolution, link address and commit flags
module alu_bjp import exu_alu_pkg::*; (
  input  dec_info_t i_info,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_pc,
  input  xlen_t     i_dp_res,
  input  logic      i_dp_cmp,
  output dp_op_t    o_dp_op,
  output xlen_t     o_dp_op1,
  output xlen_t     o_dp_op2,
  output xlen_t     o_wdat,
  output logic      o_bjp,
  output logic      o_prdt,
  output logic      o_rslv,
  output logic      o_mret,
  output logic      o_dret,
  output logic      o_fencei
);

  bjp_opc_t opc;
  logic     is_jump;
  logic     is_branch;
  xlen_t    link_incr;

  assign opc       = i_info[INFO_OPC_LSB +: OPC_W];
  assign is_jump   = (opc == BJP_JUMP);
  assign is_branch = opc inside {BJP_BEQ, BJP_BNE, BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU};
  assign link_incr = i_info[INFO_RV32] ? 32'd4 : 32'd2;  // Compressed jumps link PC+2

  always_comb begin
    case (opc)
      BJP_BEQ:  o_dp_op = DP_CMP_EQ;
      BJP_BNE:  o_dp_op = DP_CMP_NE;
      BJP_BLT:  o_dp_op = DP_CMP_LT;
      BJP_BGE:  o_dp_op = DP_CMP_GE;
      BJP_BLTU: o_dp_op = DP_CMP_LTU;
      BJP_BGEU: o_dp_op = DP_CMP_GEU;
      default:  o_dp_op = DP_ADD;  // Jump link, mret, dret, fence.i
    endcase
  end

  assign o_dp_op1 = is_jump ? i_pc      : i_rs1;
  assign o_dp_op2 = is_jump ? link_incr : i_rs2;
  assign o_wdat   = i_dp_res;

  // Jumps always resolve taken
  assign o_bjp    = is_jump | is_branch;
  assign o_prdt   = i_info[INFO_OP2IMM];
  assign o_rslv   = is_jump | i_dp_cmp;
  assign o_mret   = (opc == BJP_MRET);
  assign o_dret   = (opc == BJP_DRET);
  assign o_fencei = (opc == BJP_FENCEI);

endmodule

/* hdl/alu_disp.sv */
// Group decode, fetch exception detection, per-unit operand gating and datapath requests
module alu_disp import exu_alu_pkg::*; (
  input  dec_info_t i_info,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_imm,
  input  pc_t       i_pc,
  input  logic      i_rdwen,
  input  logic      i_ilegl,
  input  logic      i_buserr,
  input  logic      i_misalgn,
  output logic      o_sel_exc,
  output logic      o_sel_alu,
  output logic      o_sel_bjp,
  output logic      o_unsup,
  output xlen_t     o_alu_rs1,
  output xlen_t     o_alu_rs2,
  output xlen_t     o_alu_imm,
  output xlen_t     o_alu_pc,
  output xlen_t     o_bjp_rs1,
  output xlen_t     o_bjp_rs2,
  output xlen_t     o_bjp_imm,
  output xlen_t     o_bjp_pc,
  output logic      o_alu_req,
  output logic      o_bjp_req
);

  logic                  ifu_excp;
  logic [INFO_GRP_W-1:0] grp;

  assign ifu_excp = i_ilegl | i_buserr | i_misalgn;
  assign grp      = i_info[INFO_GRP_LSB +: INFO_GRP_W];

  assign o_sel_alu = ~ifu_excp & (grp == GRP_ALU);
  assign o_sel_bjp = ~ifu_excp & (grp == GRP_BJP);
  assign o_unsup   = ~ifu_excp & (grp != GRP_ALU) & (grp != GRP_BJP);
  assign o_sel_exc = ifu_excp | o_unsup;  // Unknown groups retire as illegal

  // An idle unit sees all zeros
  assign o_alu_rs1 = {XLEN{o_sel_alu}} & i_rs1;
  assign o_alu_rs2 = {XLEN{o_sel_alu}} & i_rs2;
  assign o_alu_imm = {XLEN{o_sel_alu}} & i_imm;
  assign o_alu_pc  = {XLEN{o_sel_alu}} & i_pc;
  assign o_bjp_rs1 = {XLEN{o_sel_bjp}} & i_rs1;
  assign o_bjp_rs2 = {XLEN{o_sel_bjp}} & i_rs2;
  assign o_bjp_imm = {XLEN{o_sel_bjp}} & i_imm;
  assign o_bjp_pc  = {XLEN{o_sel_bjp}} & i_pc;

  assign o_alu_req = o_sel_alu & i_rdwen;  // Result only matters with a write-back
  assign o_bjp_req = o_sel_bjp;            // Compare needed even without rd

endmodule

/* hdl/alu_dpath.sv */
// Shared ALU datapath: 33-bit adder/subtractor, shifter, logic ops and compares
module alu_dpath import exu_alu_pkg::*; (
  input  logic   i_alu_req,
  input  logic   i_bjp_req,
  input  dp_op_t i_alu_op,
  input  xlen_t  i_alu_op1,
  input  xlen_t  i_alu_op2,
  input  dp_op_t i_bjp_op,
  input  xlen_t  i_bjp_op1,
  input  xlen_t  i_bjp_op2,
  output xlen_t  o_res,
  output logic   o_cmp
);

  logic          req_any;
  dp_op_t        op;
  xlen_t         op1;
  xlen_t         op2;
  logic          is_sub;
  logic          is_unsigned;
  logic [XLEN:0] op1_ext;
  logic [XLEN:0] op2_ext;
  logic [XLEN:0] sum;
  logic          lt;
  xlen_t         xor_res;
  logic          eq;
  logic [4:0]    shamt;
  xlen_t         op1_rev;
  xlen_t         shift_in;
  xlen_t         shr;
  xlen_t         shr_rev;
  xlen_t         sra_res;
  xlen_t         res;
  logic          cmp;

  //////////////////////////////////////////////////
  // Requester mux, dispatch raises at most one
  assign req_any = i_alu_req | i_bjp_req;
  assign op  = i_alu_req ? i_alu_op : (i_bjp_req ? i_bjp_op : DP_ADD);
  assign op1 = ({XLEN{i_alu_req}} & i_alu_op1) | ({XLEN{i_bjp_req}} & i_bjp_op1);
  assign op2 = ({XLEN{i_alu_req}} & i_alu_op2) | ({XLEN{i_bjp_req}} & i_bjp_op2);

  // One adder serves add, sub and all less-than checks
  assign is_sub      = op inside {DP_SUB, DP_SLT, DP_SLTU, DP_CMP_GE, DP_CMP_LTU, DP_CMP_GEU};
  assign is_unsigned = op inside {DP_SLTU, DP_CMP_LTU, DP_CMP_GEU};
  assign op1_ext = {~is_unsigned & op1[XLEN-1], op1};
  assign op2_ext = {~is_unsigned & op2[XLEN-1], op2};
  assign sum     = op1_ext + (is_sub ? ~op2_ext : op2_ext) + {{XLEN{1'b0}}, is_sub};
  assign lt      = sum[XLEN];  // Sign of the extended difference

  assign xor_res = op1 ^ op2;
  assign eq      = ~|xor_res;

  // Right shifter only, left shift by bit reversal
  assign shamt    = op2[4:0];
  assign op1_rev  = {<<{op1}};
  assign shift_in = (op == DP_SLL) ? op1_rev : op1;
  assign shr      = shift_in >> shamt;
  assign shr_rev  = {<<{shr}};
  assign sra_res  = shr | ({XLEN{op1[XLEN-1]}} & ~({XLEN{1'b1}} >> shamt));

  always_comb begin
    res = '0;
    cmp = 1'b0;
    case (op)
      DP_ADD, DP_SUB: res = sum[XLEN-1:0];
      DP_XOR:         res = xor_res;
      DP_SLL:         res = shr_rev;
      DP_SRL:         res = shr;
      DP_SRA:         res = sra_res;
      DP_OR:          res = op1 | op2;
      DP_AND:         res = op1 & op2;
      DP_SLT, DP_SLTU: begin  // Also covers the signed branch compare
        res = {{(XLEN-1){1'b0}}, lt};
        cmp = lt;
      end
      DP_PASS2:       res = op2;
      DP_CMP_EQ:      cmp = eq;
      DP_CMP_NE:      cmp = ~eq;
      DP_CMP_GE, DP_CMP_GEU: cmp = ~lt;
      DP_CMP_LTU:     cmp = lt;
      default:        res = '0;
    endcase
  end

  assign o_res = req_any ? res : '0;
  assign o_cmp = req_any & cmp;

endmodule

/* hdl/alu_rglr.sv */
// Regular ALU decode: operand selection, datapath opcode and system commit flags
module alu_rglr import exu_alu_pkg::*; (
  input  dec_info_t i_info,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_imm,
  input  xlen_t     i_pc,
  input  xlen_t     i_dp_res,
  output dp_op_t    o_dp_op,
  output xlen_t     o_dp_op1,
  output xlen_t     o_dp_op2,
  output xlen_t     o_wdat,
  output logic      o_ecall,
  output logic      o_ebreak,
  output logic      o_wfi
);

  alu_opc_t opc;

  assign opc = i_info[INFO_OPC_LSB +: OPC_W];

  // auipc and jal-style ops take the PC
  assign o_dp_op1 = i_info[INFO_OP1PC]  ? i_pc  : i_rs1;
  assign o_dp_op2 = i_info[INFO_OP2IMM] ? i_imm : i_rs2;

  //////////////////////////////////////////////////
  // Opcode to datapath operation
  always_comb begin
    case (opc)
      ALU_ADD:  o_dp_op = DP_ADD;
      ALU_SUB:  o_dp_op = DP_SUB;
      ALU_XOR:  o_dp_op = DP_XOR;
      ALU_SLL:  o_dp_op = DP_SLL;
      ALU_SRL:  o_dp_op = DP_SRL;
      ALU_SRA:  o_dp_op = DP_SRA;
      ALU_OR:   o_dp_op = DP_OR;
      ALU_AND:  o_dp_op = DP_AND;
      ALU_SLT:  o_dp_op = DP_SLT;
      ALU_SLTU: o_dp_op = DP_SLTU;
      ALU_LUI:  o_dp_op = DP_PASS2;  // Immediate arrives pre-shifted
      ALU_ECALL, ALU_EBREAK, ALU_WFI, ALU_NOP: begin
        o_dp_op = DP_ADD;
      end
      default:  o_dp_op = DP_ADD;
    endcase
  end

  assign o_wdat = i_dp_res;

  // System ops never write back
  assign o_ecall  = (opc == ALU_ECALL);
  assign o_ebreak = (opc == ALU_EBREAK);
  assign o_wfi    = (opc == ALU_WFI);

endmodule

/* hdl/alu_wbck_arbt.sv */
// Result arbiter: write-back data select, error rule and commit/write-back handshake
module alu_wbck_arbt import exu_alu_pkg::*; (
  input  logic  i_valid,
  input  logic  i_sel_exc,
  input  logic  i_sel_alu,
  input  logic  i_sel_bjp,
  input  logic  i_unsup,
  input  logic  i_rdwen,
  input  logic  i_ilegl,
  input  xlen_t i_alu_wdat,
  input  xlen_t i_bjp_wdat,
  input  logic  i_ecall,
  input  logic  i_ebreak,
  input  logic  i_wfi,
  input  logic  i_bjp,
  input  logic  i_prdt,
  input  logic  i_rslv,
  input  logic  i_mret,
  input  logic  i_dret,
  input  logic  i_fencei,
  input  logic  i_cmt_ready,
  input  logic  i_wbck_ready,
  output logic  o_ready,
  output logic  o_cmt_valid,
  output logic  o_wbck_valid,
  output xlen_t o_wbck_wdat,
  output logic  o_cmt_bjp,
  output logic  o_cmt_bjp_prdt,
  output logic  o_cmt_bjp_rslv,
  output logic  o_cmt_mret,
  output logic  o_cmt_dret,
  output logic  o_cmt_fencei,
  output logic  o_cmt_ecall,
  output logic  o_cmt_ebreak,
  output logic  o_cmt_wfi,
  output logic  o_cmt_ifu_ilegl
);

  logic wbck_err;
  logic need_wbck;

  // Exception path contributes zero data
  assign o_wbck_wdat = ({XLEN{i_sel_alu}} & i_alu_wdat) | ({XLEN{i_sel_bjp}} & i_bjp_wdat);

  assign wbck_err  = i_sel_exc | (i_sel_alu & (i_ecall | i_ebreak | i_wfi));
  assign need_wbck = i_rdwen & ~wbck_err;

  //////////////////////////////////////////////////
  // Commit always, write back only when needed
  assign o_ready      = i_cmt_ready & (need_wbck ? i_wbck_ready : 1'b1);
  assign o_wbck_valid = i_valid & need_wbck & i_cmt_ready;
  assign o_cmt_valid  = i_valid & (need_wbck ? i_wbck_ready : 1'b1);

  assign o_cmt_bjp       = i_sel_bjp & i_bjp;
  assign o_cmt_bjp_prdt  = i_sel_bjp & i_prdt;
  assign o_cmt_bjp_rslv  = i_sel_bjp & i_rslv;
  assign o_cmt_mret      = i_sel_bjp & i_mret;
  assign o_cmt_dret      = i_sel_bjp & i_dret;
  assign o_cmt_fencei    = i_sel_bjp & i_fencei;
  assign o_cmt_ecall     = i_sel_alu & i_ecall;
  assign o_cmt_ebreak    = i_sel_alu & i_ebreak;
  assign o_cmt_wfi       = i_sel_alu & i_wfi;
  assign o_cmt_ifu_ilegl = i_ilegl | i_unsup;  // Unknown group reported as illegal

endmodule

/* hdl/exu_alu_pkg.sv */
// Data widths, decode-info field positions, group codes and unit opcodes for the EXU ALU
package exu_alu_pkg;

  localparam int XLEN       = 32;
  localparam int PC_W       = 32;
  localparam int RFIDX_W    = 5;
  localparam int INFO_W     = 12;
  localparam int INFO_GRP_W = 3;
  localparam int OPC_W      = 4;

  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [PC_W-1:0]    pc_t;
  typedef logic [RFIDX_W-1:0] rfidx_t;
  typedef logic [INFO_W-1:0]  dec_info_t;
  typedef logic [OPC_W-1:0]   alu_opc_t;
  typedef logic [OPC_W-1:0]   bjp_opc_t;
  typedef logic [OPC_W-1:0]   dp_op_t;

  //////////////////////////////////////////////////
  // Decode-info layout
  localparam int INFO_GRP_LSB = 0;
  localparam int INFO_OPC_LSB = 3;
  localparam int INFO_OP2IMM  = 7;  // BJP reuses it as the prediction bit
  localparam int INFO_OP1PC   = 8;
  localparam int INFO_RV32    = 9;  // Bits 10 and 11 spare

  localparam logic [INFO_GRP_W-1:0] GRP_ALU = 3'd0;
  localparam logic [INFO_GRP_W-1:0] GRP_BJP = 3'd1;

  //////////////////////////////////////////////////
  // Regular ALU opcodes
  localparam alu_opc_t ALU_ADD    = 4'd0;
  localparam alu_opc_t ALU_SUB    = 4'd1;
  localparam alu_opc_t ALU_XOR    = 4'd2;
  localparam alu_opc_t ALU_SLL    = 4'd3;
  localparam alu_opc_t ALU_SRL    = 4'd4;
  localparam alu_opc_t ALU_SRA    = 4'd5;
  localparam alu_opc_t ALU_OR     = 4'd6;
  localparam alu_opc_t ALU_AND    = 4'd7;
  localparam alu_opc_t ALU_SLT    = 4'd8;
  localparam alu_opc_t ALU_SLTU   = 4'd9;
  localparam alu_opc_t ALU_LUI    = 4'd10;
  localparam alu_opc_t ALU_ECALL  = 4'd11;
  localparam alu_opc_t ALU_EBREAK = 4'd12;
  localparam alu_opc_t ALU_WFI    = 4'd13;
  localparam alu_opc_t ALU_NOP    = 4'd14;

  // Branch and jump opcodes
  localparam bjp_opc_t BJP_JUMP   = 4'd0;
  localparam bjp_opc_t BJP_BEQ    = 4'd1;
  localparam bjp_opc_t BJP_BNE    = 4'd2;
  localparam bjp_opc_t BJP_BLT    = 4'd3;
  localparam bjp_opc_t BJP_BGE    = 4'd4;
  localparam bjp_opc_t BJP_BLTU   = 4'd5;
  localparam bjp_opc_t BJP_BGEU   = 4'd6;
  localparam bjp_opc_t BJP_MRET   = 4'd7;
  localparam bjp_opc_t BJP_DRET   = 4'd8;
  localparam bjp_opc_t BJP_FENCEI = 4'd9;

  // Shared datapath operations, codes 0-9 line up with the ALU opcodes
  localparam dp_op_t DP_ADD     = 4'd0;
  localparam dp_op_t DP_SUB     = 4'd1;
  localparam dp_op_t DP_XOR     = 4'd2;
  localparam dp_op_t DP_SLL     = 4'd3;
  localparam dp_op_t DP_SRL     = 4'd4;
  localparam dp_op_t DP_SRA     = 4'd5;
  localparam dp_op_t DP_OR      = 4'd6;
  localparam dp_op_t DP_AND     = 4'd7;
  localparam dp_op_t DP_SLT     = 4'd8;
  localparam dp_op_t DP_SLTU    = 4'd9;
  localparam dp_op_t DP_PASS2   = 4'd10;
  localparam dp_op_t DP_CMP_EQ  = 4'd11;
  localparam dp_op_t DP_CMP_NE  = 4'd12;
  localparam dp_op_t DP_CMP_LT  = DP_SLT;  // Signed less-than shares the SLT code
  localparam dp_op_t DP_CMP_GE  = 4'd13;
  localparam dp_op_t DP_CMP_LTU = 4'd14;
  localparam dp_op_t DP_CMP_GEU = 4'd15;

endpackage

/* hdl/exu_alu_top.sv */
// Execution-stage ALU top level: dispatch, regular ALU, BJP, shared datapath and arbiter
module exu_alu_top import exu_alu_pkg::*; (
  input  logic      clk,        // Pipeline clock, no state in this stage
  input  logic      i_rst_n,
  // Issue side
  input  logic      i_valid,
  output logic      o_ready,
  input  dec_info_t i_info,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_imm,
  input  pc_t       i_pc,
  input  rfidx_t    i_rdidx,
  input  logic      i_rdwen,
  input  logic      i_ilegl,
  input  logic      i_buserr,
  input  logic      i_misalgn,
  // Commit port
  output logic      o_cmt_valid,
  input  logic      i_cmt_ready,
  output pc_t       o_cmt_pc,
  output xlen_t     o_cmt_imm,
  output logic      o_cmt_rv32,
  output logic      o_cmt_bjp,
  output logic      o_cmt_bjp_prdt,
  output logic      o_cmt_bjp_rslv,
  output logic      o_cmt_mret,
  output logic      o_cmt_dret,
  output logic      o_cmt_fencei,
  output logic      o_cmt_ecall,
  output logic      o_cmt_ebreak,
  output logic      o_cmt_wfi,
  output logic      o_cmt_ifu_misalgn,
  output logic      o_cmt_ifu_buserr,
  output logic      o_cmt_ifu_ilegl,
  // Write-back port
  output logic      o_wbck_valid,
  input  logic      i_wbck_ready,
  output xlen_t     o_wbck_wdat,
  output rfidx_t    o_wbck_rdidx
);

  logic   sel_exc, sel_alu, sel_bjp, unsup;
  logic   alu_req, bjp_req;
  xlen_t  alu_rs1, alu_rs2, alu_imm, alu_pc;
  xlen_t  bjp_rs1, bjp_rs2, bjp_pc;
  dp_op_t alu_dp_op, bjp_dp_op;
  xlen_t  alu_dp_op1, alu_dp_op2, bjp_dp_op1, bjp_dp_op2;
  xlen_t  dp_res;
  logic   dp_cmp;
  xlen_t  alu_wdat, bjp_wdat;
  logic   ecall, ebreak, wfi;
  logic   bjp, prdt, rslv, mret, dret, fencei;

  alu_disp u_disp (
    .i_info    (i_info),    .i_rs1     (i_rs1),     .i_rs2     (i_rs2),
    .i_imm     (i_imm),     .i_pc      (i_pc),      .i_rdwen   (i_rdwen),
    .i_ilegl   (i_ilegl),   .i_buserr  (i_buserr),  .i_misalgn (i_misalgn),
    .o_sel_exc (sel_exc),   .o_sel_alu (sel_alu),   .o_sel_bjp (sel_bjp),
    .o_unsup   (unsup),
    .o_alu_rs1 (alu_rs1),   .o_alu_rs2 (alu_rs2),   .o_alu_imm (alu_imm),
    .o_alu_pc  (alu_pc),
    .o_bjp_rs1 (bjp_rs1),   .o_bjp_rs2 (bjp_rs2),
    .o_bjp_imm (),          // Branch target is resolved upstream
    .o_bjp_pc  (bjp_pc),
    .o_alu_req (alu_req),   .o_bjp_req (bjp_req)
  );

  alu_rglr u_rglr (
    .i_info   (i_info),     .i_rs1    (alu_rs1),    .i_rs2    (alu_rs2),
    .i_imm    (alu_imm),    .i_pc     (alu_pc),     .i_dp_res (dp_res),
    .o_dp_op  (alu_dp_op),  .o_dp_op1 (alu_dp_op1), .o_dp_op2 (alu_dp_op2),
    .o_wdat   (alu_wdat),   .o_ecall  (ecall),      .o_ebreak (ebreak),
    .o_wfi    (wfi)
  );

  alu_bjp u_bjp (
    .i_info   (i_info),     .i_rs1    (bjp_rs1),    .i_rs2    (bjp_rs2),
    .i_pc     (bjp_pc),     .i_dp_res (dp_res),     .i_dp_cmp (dp_cmp),
    .o_dp_op  (bjp_dp_op),  .o_dp_op1 (bjp_dp_op1), .o_dp_op2 (bjp_dp_op2),
    .o_wdat   (bjp_wdat),   .o_bjp    (bjp),        .o_prdt   (prdt),
    .o_rslv   (rslv),       .o_mret   (mret),       .o_dret   (dret),
    .o_fencei (fencei)
  );

  alu_dpath u_dpath (
    .i_alu_req (alu_req),    .i_bjp_req (bjp_req),
    .i_alu_op  (alu_dp_op),  .i_alu_op1 (alu_dp_op1), .i_alu_op2 (alu_dp_op2),
    .i_bjp_op  (bjp_dp_op),  .i_bjp_op1 (bjp_dp_op1), .i_bjp_op2 (bjp_dp_op2),
    .o_res     (dp_res),     .o_cmp     (dp_cmp)
  );

  alu_wbck_arbt u_arbt (
    .i_valid        (i_valid),        .i_sel_exc      (sel_exc),
    .i_sel_alu      (sel_alu),        .i_sel_bjp      (sel_bjp),
    .i_unsup        (unsup),          .i_rdwen        (i_rdwen),
    .i_ilegl        (i_ilegl),        .i_alu_wdat     (alu_wdat),
    .i_bjp_wdat     (bjp_wdat),       .i_ecall        (ecall),
    .i_ebreak       (ebreak),         .i_wfi          (wfi),
    .i_bjp          (bjp),            .i_prdt         (prdt),
    .i_rslv         (rslv),           .i_mret         (mret),
    .i_dret         (dret),           .i_fencei       (fencei),
    .i_cmt_ready    (i_cmt_ready),    .i_wbck_ready   (i_wbck_ready),
    .o_ready        (o_ready),        .o_cmt_valid    (o_cmt_valid),
    .o_wbck_valid   (o_wbck_valid),   .o_wbck_wdat    (o_wbck_wdat),
    .o_cmt_bjp      (o_cmt_bjp),      .o_cmt_bjp_prdt (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv (o_cmt_bjp_rslv), .o_cmt_mret     (o_cmt_mret),
    .o_cmt_dret     (o_cmt_dret),     .o_cmt_fencei   (o_cmt_fencei),
    .o_cmt_ecall    (o_cmt_ecall),    .o_cmt_ebreak   (o_cmt_ebreak),
    .o_cmt_wfi      (o_cmt_wfi),      .o_cmt_ifu_ilegl (o_cmt_ifu_ilegl)
  );

  // Commit side-band straight from the issue side
  assign o_cmt_pc          = i_pc;
  assign o_cmt_imm         = i_imm;
  assign o_cmt_rv32        = i_info[INFO_RV32];
  assign o_cmt_ifu_misalgn = i_misalgn;
  assign o_cmt_ifu_buserr  = i_buserr;
  assign o_wbck_rdidx      = i_rdidx;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the EXU ALU testbench with Verilator, run it and grade the log
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_exu_alu -f exu_alu.f -o tb_exu_alu \
  && ./obj_dir/tb_exu_alu | tee sim.log \
  || { echo "Build or run step failed"; exit 1; }

grep -q "Simulation PASSED" sim.log \
  && echo "Test run passed" \
  || { echo "Test run failed, see sim.log"; exit 1; }

/* verif/alu_tests.txt */
// info rs1 rs2 imm pc rdidx rdwen ilegl buserr misalgn exp_wdat exp_need exp_flags (all hex)
// flags: bjp prdt rslv mret dret fencei ecall ebreak wfi misalgn buserr ilegl
// Regular ALU, register and immediate operands, rs1 and pc operand
200 00000005 00000007 00000000 00000100 01 1 0 0 0 0000000c 1 000
280 00000100 00000000 fffffff0 00000104 02 1 0 0 0 000000f0 1 000
380 00000000 00000000 00012000 80000000 03 1 0 0 0 80012000 1 000
300 00000000 00000010 00000000 00000200 03 1 0 0 0 00000210 1 000
208 00000003 00000005 00000000 00000108 04 1 0 0 0 fffffffe 1 000
210 a5a5a5a5 0f0f0f0f 00000000 0000010c 05 1 0 0 0 aaaaaaaa 1 000
218 00000003 00000008 00000000 00000110 06 1 0 0 0 00000300 1 000
298 00000001 00000000 0000001f 00000110 06 1 0 0 0 80000000 1 000
220 80000000 00000004 00000000 00000114 07 1 0 0 0 08000000 1 000
228 80000000 00000004 00000000 00000118 08 1 0 0 0 f8000000 1 000
2a8 7ffffff0 00000000 00000024 0000011c 09 1 0 0 0 07ffffff 1 000
230 0000f000 0000000f 00000000 00000120 0a 1 0 0 0 0000f00f 1 000
2b8 12345678 00000000 0000ff00 00000124 0b 1 0 0 0 00005600 1 000
240 ffffffff 00000001 00000000 00000128 0c 1 0 0 0 00000001 1 000
248 ffffffff 00000001 00000000 0000012c 0d 1 0 0 0 00000000 1 000
2c0 00000005 00000000 fffffffb 00000130 0e 1 0 0 0 00000000 1 000
2d0 00000000 00000000 abcde000 00000134 1f 1 0 0 0 abcde000 1 000
// No rd write, then ecall, ebreak and wfi with rdwen high
200 00000001 00000001 00000000 00000138 10 0 0 0 0 00000000 0 000
258 00000000 00000000 00000000 0000013c 11 1 0 0 0 00000000 0 020
260 00000000 00000000 00000000 00000140 12 1 0 0 0 00000000 0 010
268 00000000 00000000 00000000 00000144 13 1 0 0 0 00000000 0 008
// Branches, jumps with rv32 set and clear, mret dret fencei
289 00000010 00000010 00000000 00001000 00 0 0 0 0 00000000 0 e00
289 00000001 00000002 00000000 00001004 00 0 0 0 0 00000000 0 c00
211 00000001 00000002 00000000 00001008 00 0 0 0 0 00000000 0 a00
219 fffffff0 00000001 00000000 0000100c 00 0 0 0 0 00000000 0 a00
221 fffffff0 00000001 00000000 00001010 00 0 0 0 0 00000000 0 800
229 fffffff0 00000001 00000000 00001014 00 0 0 0 0 00000000 0 800
2b1 fffffff0 00000001 00000000 00001018 00 0 0 0 0 00000000 0 e00
281 00000000 00000000 00000000 00001000 01 1 0 0 0 00001004 1 e00
001 00000000 00000000 00000000 00002000 01 1 0 0 0 00002002 1 a00
239 00000000 00000000 00000000 00002004 00 0 0 0 0 00000000 0 100
241 00000000 00000000 00000000 00002008 00 0 0 0 0 00000000 0 080
249 00000000 00000000 00000000 0000200c 00 0 0 0 0 00000000 0 040
// Fetch exceptions and an unsupported group
200 00000005 00000007 00000000 00000200 05 1 1 0 0 00000000 0 001
200 00000005 00000007 00000000 00000204 05 1 0 1 0 00000000 0 002
200 00000005 00000007 00000000 00000208 05 1 0 0 1 00000000 0 004
202 00000005 00000007 00000000 0000020c 05 1 0 0 0 00000000 0 001
289 00000010 00000010 00000000 00000210 00 0 0 1 0 00000000 0 002

/* verif/tb_exu_alu_checks.svh */
// Commit flag vector type, error counters and typed compare tasks for the EXU ALU testbench
`ifndef TB_EXU_ALU_CHECKS_SVH
`define TB_EXU_ALU_CHECKS_SVH

  // {bjp, prdt, rslv, mret, dret, fencei, ecall, ebreak, wfi, misalgn, buserr, ilegl}
  typedef logic [11:0] flag_vec_t;

  int data_errs = 0;  // Write-back data and index
  int flag_errs = 0;  // Commit flags and handshake bits
  int run_errs  = 0;

  task automatic check_xlen(input xlen_t act, input xlen_t exp, input string what);
    if (act !== exp) begin
      data_errs++;
      $display("Fail at time %0t: %s is %08h, expected %08h", $time, what, act, exp);
    end
  endtask

  task automatic check_rfidx(input rfidx_t act, input rfidx_t exp, input string what);
    if (act !== exp) begin
      data_errs++;
      $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, act, exp);
    end
  endtask

  task automatic check_flags(input flag_vec_t act, input flag_vec_t exp, input string what);
    if (act !== exp) begin
      flag_errs++;
      $display("Fail at time %0t: %s is %03h, expected %03h", $time, what, act, exp);
    end
  endtask

`endif

/* verif/tb_exu_alu.sv */
// Testbench top for the EXU ALU: clock, reset, vector file reader, drive and ready stalls
module tb_exu_alu import exu_alu_pkg::*; ();

  localparam int    CLK_PERIOD = 40;
  localparam int    DRIVE_DLY  = 1;   // After the rising edge
  localparam int    MAX_WAIT   = 50;  // Cycles per vector
  localparam string TEST_FILE  = "verif/alu_tests.txt";

  `include "tb_exu_alu_checks.svh"

  logic      clk;
  logic      i_rst_n;
  logic      i_valid;
  logic      o_ready;
  dec_info_t i_info;
  xlen_t     i_rs1, i_rs2, i_imm;
  pc_t       i_pc;
  rfidx_t    i_rdidx;
  logic      i_rdwen, i_ilegl, i_buserr, i_misalgn;
  logic      o_cmt_valid, i_cmt_ready;
  pc_t       o_cmt_pc;
  xlen_t     o_cmt_imm;
  logic      o_cmt_rv32;
  logic      o_cmt_bjp, o_cmt_bjp_prdt, o_cmt_bjp_rslv;
  logic      o_cmt_mret, o_cmt_dret, o_cmt_fencei;
  logic      o_cmt_ecall, o_cmt_ebreak, o_cmt_wfi;
  logic      o_cmt_ifu_misalgn, o_cmt_ifu_buserr, o_cmt_ifu_ilegl;
  logic      o_wbck_valid, i_wbck_ready;
  xlen_t     o_wbck_wdat;
  rfidx_t    o_wbck_rdidx;

  int        seed;
  flag_vec_t cmt_flags;

  exu_alu_top dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  assign cmt_flags = {o_cmt_bjp, o_cmt_bjp_prdt, o_cmt_bjp_rslv, o_cmt_mret, o_cmt_dret,
                      o_cmt_fencei, o_cmt_ecall, o_cmt_ebreak, o_cmt_wfi,
                      o_cmt_ifu_misalgn, o_cmt_ifu_buserr, o_cmt_ifu_ilegl};

  // Readies high three times out of four
  task automatic shuffle_readies();
    int rnd;
    rnd          = $random(seed);
    i_cmt_ready  = |rnd[1:0];
    i_wbck_ready = |rnd[3:2];
  endtask

  //////////////////////////////////////////////////
  initial begin
    int        fd;
    int        n;
    int        waited;
    int        vec_cnt;
    bit        accepted;
    bit        timed_out;
    string     line;
    dec_info_t v_info;
    xlen_t     v_rs1, v_rs2, v_imm, exp_wdat;
    pc_t       v_pc;
    rfidx_t    v_rdidx;
    logic      v_rdwen, v_ilegl, v_buserr, v_misalgn, exp_need;
    logic      exp_cmt_v, exp_wbck_v;
    flag_vec_t exp_flags;

    seed         = 32'h841c;
    vec_cnt      = 0;
    timed_out    = 1'b0;
    clk          = 1'b0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_info       = '0;
    i_rs1        = '0;
    i_rs2        = '0;
    i_imm        = '0;
    i_pc         = '0;
    i_rdidx      = '0;
    i_rdwen      = 1'b0;
    i_ilegl      = 1'b0;
    i_buserr     = 1'b0;
    i_misalgn    = 1'b0;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;

    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    i_rst_n = 1'b1;
    check_flags({10'b0, o_cmt_valid, o_wbck_valid}, '0, "valids while idle");
    shuffle_readies();

    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", TEST_FILE);
      run_errs++;
    end

    while (fd != 0 && !timed_out && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 4 || line.substr(0, 1) == "//") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v_info, v_rs1, v_rs2, v_imm, v_pc, v_rdidx, v_rdwen,
                  v_ilegl, v_buserr, v_misalgn, exp_wdat, exp_need, exp_flags);
      if (n != 13) begin
        $display("Malformed vector line: %s", line);
        run_errs++;
        continue;
      end
      vec_cnt++;
      i_info    = v_info;
      i_rs1     = v_rs1;
      i_rs2     = v_rs2;
      i_imm     = v_imm;
      i_pc      = v_pc;
      i_rdidx   = v_rdidx;
      i_rdwen   = v_rdwen;
      i_ilegl   = v_ilegl;
      i_buserr  = v_buserr;
      i_misalgn = v_misalgn;
      i_valid   = 1'b1;
      waited    = 0;
      accepted  = 1'b0;

      // Hold the vector until an edge with o_ready high
      while (!accepted && !timed_out) begin
        @(negedge clk);
        exp_cmt_v  = exp_need ? i_wbck_ready : 1'b1;
        exp_wbck_v = exp_need & i_cmt_ready;
        check_flags({11'b0, o_ready}, {11'b0, i_cmt_ready & exp_cmt_v}, "o_ready");
        check_flags({10'b0, o_cmt_valid, o_wbck_valid}, {10'b0, exp_cmt_v, exp_wbck_v},
                    "commit and write-back valid");
        if (o_ready) begin
          accepted = 1'b1;
          check_flags(cmt_flags, exp_flags, "commit flags");
          check_flags({11'b0, o_cmt_rv32}, {11'b0, v_info[INFO_RV32]}, "o_cmt_rv32");
          check_xlen(o_cmt_pc, v_pc, "o_cmt_pc");
          check_xlen(o_cmt_imm, v_imm, "o_cmt_imm");
          if (exp_need) begin
            check_xlen(o_wbck_wdat, exp_wdat, "o_wbck_wdat");
            check_rfidx(o_wbck_rdidx, v_rdidx, "o_wbck_rdidx");
          end
        end
        @(posedge clk);
        #DRIVE_DLY;
        shuffle_readies();
        waited++;
        if (!accepted && waited >= MAX_WAIT) begin
          $display("Timeout: vector %0d was not accepted within %0d cycles", vec_cnt, MAX_WAIT);
          run_errs++;
          timed_out = 1'b1;
        end
      end
    end
    i_valid = 1'b0;

    if (fd != 0) $fclose(fd);
    if (vec_cnt == 0) begin
      $display("No test vectors were read");
      run_errs++;
    end
    $display("Vectors %0d, errors: data %0d, flags %0d, run %0d",
             vec_cnt, data_errs, flag_errs, run_errs);
    if (data_errs + flag_errs + run_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
